/* Bender.yml */
package:
  name: dkjr_bus_ctrl

sources:
  - logic/dkjr_pkg.sv
  - logic/dkjr_addr_decode.sv
  - logic/dkjr_latch_bank.sv
  - logic/dkjr_cpu_ctrl.sv
  - logic/dkjr_bus_ctrl.sv
  - target: test
    files:
      - test/dkjr_bus_ctrl_props.sv
      - test/dkjr_bus_ctrl_tb.sv

/* dkjr_bus_ctrl.f */
logic/dkjr_pkg.sv
logic/dkjr_addr_decode.sv
logic/dkjr_latch_bank.sv
logic/dkjr_cpu_ctrl.sv
logic/dkjr_bus_ctrl.sv
test/dkjr_bus_ctrl_props.sv
test/dkjr_bus_ctrl_tb.sv

/* logic/dkjr_addr_decode.sv */
// Combinational memory-map decoder for the Z80 bus
// Produces every chip select, the latch write strobes and the VRAM access flag
`timescale 1ns/1ps

module dkjr_addr_decode import dkjr_pkg::*; (
   input  addr_t      addr,
   input  logic       mreq_n,
   input  logic       rd_n,
   input  logic       wr_n,
   input  logic       rfsh_n,
   input  logic       wr_gate,     // Low blocks video RAM writes
   output logic       rom_cs_n,
   output logic [2:0] ram_cs_n,
   output logic       vid_grp_n,   // Object plus tile RAM group
   output logic       obj_rq_n,
   output logic       obj_rd_n,
   output logic       obj_wr_n,
   output logic       vram_rd_n,
   output logic       vram_wr_n,
   output logic       dma_cs_n,
   output logic [3:0] in_oe_n,     // Input port read enables
   output logic [3:0] latch_wr_n,  // Control latch write strobes
   output logic       vram_acc_n   // Any CPU access to tile RAM
);

   logic [7:0] page_n;  // 4 KB pages of the lower 32 KB
   logic [3:0] sub_n;   // 1 KB windows inside page 7
   logic [1:0] ram_idx; // Work RAM bank number
   logic [2:0] io_idx;  // 128-byte window inside the I/O area
   logic       mem_rd;
   logic       mem_wr;

   assign mem_rd = ~mreq_n & ~rd_n;
   assign mem_wr = ~mreq_n & ~wr_n;

   // ================================================
   // First stage, 4 KB pages
   // ================================================
   // Upper 32 KB is unused, refresh kills the whole tree here
   always_comb begin
      page_n = '1;
      if (rfsh_n && !addr[15])
         page_n[addr[14:12]] = 1'b0;
   end

   assign rom_cs_n = &page_n[ROM_TOP[14:12]:0]; // Pages 0 to 5

   // ================================================
   // Second stage, 1 KB windows and 128-byte ports
   // ================================================
   always_comb begin
      sub_n = '1;
      if (!page_n[OBJ_BASE[14:12]])
         sub_n[addr[11:10]] = 1'b0;
   end

   assign ram_idx = 2'((addr - RAM_BASE) >> $clog2(RAM_BANK_SIZE));
   assign io_idx  = 3'((addr - IO_BASE) >> $clog2(IO_STRIDE));

   // Work RAM, fourth bank slot left unused
   always_comb begin
      for (int k = 0; k < 3; k++) begin
         ram_cs_n[k] = page_n[RAM_BASE[14:12]] | ~(mem_rd | mem_wr)
                     | (ram_idx != 2'(k));
      end
   end

   // Video group, address only
   assign vid_grp_n = sub_n[OBJ_BASE[11:10]] & sub_n[VRAM_BASE[11:10]];

   // Object RAM
   assign obj_rq_n = sub_n[OBJ_BASE[11:10]] | mreq_n;
   assign obj_rd_n = sub_n[OBJ_BASE[11:10]] | ~mem_rd;
   assign obj_wr_n = sub_n[OBJ_BASE[11:10]] | ~(mem_wr & wr_gate); // Held off during wait

   // Tile RAM
   assign vram_rd_n  = sub_n[VRAM_BASE[11:10]] | ~mem_rd;
   assign vram_wr_n  = sub_n[VRAM_BASE[11:10]] | ~(mem_wr & wr_gate);
   assign vram_acc_n = sub_n[VRAM_BASE[11:10]] | mreq_n; // Feeds the wait generator

   assign dma_cs_n = sub_n[DMA_BASE[11:10]]; // Address only, DMA qualifies itself

   // I/O area, reads go to the input ports and writes to the latches
   always_comb begin
      for (int k = 0; k < 4; k++) begin
         in_oe_n[k]    = sub_n[IO_BASE[11:10]] | ~mem_rd | (io_idx != 3'(k));
         latch_wr_n[k] = sub_n[IO_BASE[11:10]] | ~mem_wr | (io_idx != 3'(k));
      end
   end

endmodule

/* logic/dkjr_bus_ctrl.sv */
// Top level of the CPU-side bus control
// Ties the address decoder, control latches and wait/NMI logic together
`timescale 1ns/1ps

module dkjr_bus_ctrl import dkjr_pkg::*; (
   input  logic       I_CLK12M,
   input  logic       I_RESET_n,
   input  logic       cpu_ce,
   input  addr_t      addr,
   input  data_t      data,
   input  logic       mreq_n,
   input  logic       rd_n,
   input  logic       wr_n,
   input  logic       rfsh_n,
   input  logic       vram_busy_n,
   input  logic       vblk_n,
   output logic       rom_cs_n,
   output logic [2:0] ram_cs_n,
   output logic       vid_grp_n,
   output logic       obj_rq_n,
   output logic       obj_rd_n,
   output logic       obj_wr_n,
   output logic       vram_rd_n,
   output logic       vram_wr_n,
   output logic       dma_cs_n,
   output logic [3:0] in_oe_n,
   output logic       wait_n,
   output logic       nmi_n,
   output logic [1:0] gfx_ctrl,
   output ctrl_byte_t sys_ctrl,
   output ctrl_byte_t snd_ctrl,
   output snd_cmd_t   snd_cmd
);

   logic [3:0] latch_wr_n; // Decoder to latch bank
   logic       vram_acc_n; // Decoder to wait FSM
   logic       wr_gate;    // Wait FSM back to decoder
   logic       nmi_en;     // System latch to NMI logic

   // ================================================
   // Submodules
   // ================================================
   dkjr_addr_decode i_decode (
      .addr       (addr),
      .mreq_n     (mreq_n),
      .rd_n       (rd_n),
      .wr_n       (wr_n),
      .rfsh_n     (rfsh_n),
      .wr_gate    (wr_gate),
      .rom_cs_n   (rom_cs_n),
      .ram_cs_n   (ram_cs_n),
      .vid_grp_n  (vid_grp_n),
      .obj_rq_n   (obj_rq_n),
      .obj_rd_n   (obj_rd_n),
      .obj_wr_n   (obj_wr_n),
      .vram_rd_n  (vram_rd_n),
      .vram_wr_n  (vram_wr_n),
      .dma_cs_n   (dma_cs_n),
      .in_oe_n    (in_oe_n),
      .latch_wr_n (latch_wr_n),
      .vram_acc_n (vram_acc_n)
   );

   dkjr_latch_bank i_latches (
      .I_CLK12M   (I_CLK12M),
      .I_RESET_n  (I_RESET_n),
      .addr       (addr),
      .data       (data),
      .latch_wr_n (latch_wr_n),
      .gfx_ctrl   (gfx_ctrl),
      .sys_ctrl   (sys_ctrl),
      .snd_ctrl   (snd_ctrl),
      .snd_cmd    (snd_cmd),
      .nmi_en     (nmi_en)
   );

   dkjr_cpu_ctrl i_cpu_ctrl (
      .I_CLK12M    (I_CLK12M),
      .I_RESET_n   (I_RESET_n),
      .cpu_ce      (cpu_ce),
      .vram_acc_n  (vram_acc_n),
      .vram_busy_n (vram_busy_n),
      .vblk_n      (vblk_n),
      .nmi_en      (nmi_en),
      .wait_n      (wait_n),
      .wr_gate     (wr_gate),
      .nmi_n       (nmi_n)
   );

endmodule

/* logic/dkjr_cpu_ctrl.sv */
// CPU wait-state generator, video write gate and vertical-blank NMI
// Stretches tile RAM accesses while video owns the RAM, released at vblank
`timescale 1ns/1ps

module dkjr_cpu_ctrl import dkjr_pkg::*; (
   input  logic I_CLK12M,
   input  logic I_RESET_n,
   input  logic cpu_ce,      // One pulse per CPU clock
   input  logic vram_acc_n,
   input  logic vram_busy_n, // Low while video reads tile RAM
   input  logic vblk_n,
   input  logic nmi_en,
   output logic wait_n,
   output logic wr_gate,     // High lets video RAM writes through
   output logic nmi_n
);

   wait_state_t state, state_nxt;
   logic        wr_dly;  // wait_n one cpu_ce late
   logic        vblk_q;  // Previous vblk_n for edge detect
   logic        nmi_q_n;

   // ================================================
   // Wait FSM
   // ================================================
   always_comb begin
      state_nxt = state;
      case (state)
         WAIT_IDLE: begin
            if (cpu_ce && !vram_acc_n && !vram_busy_n && vblk_n)
               state_nxt = WAIT_HOLD;
         end
         WAIT_HOLD: begin
            if (!vblk_n) // Vblank releases without waiting for cpu_ce
               state_nxt = WAIT_RELEASE;
         end
         WAIT_RELEASE: begin
            if (cpu_ce && vram_acc_n) // Stretched access has ended
               state_nxt = WAIT_IDLE;
         end
         default: state_nxt = WAIT_IDLE;
      endcase
   end

   always_ff @(posedge I_CLK12M or negedge I_RESET_n) begin
      if (!I_RESET_n) begin
         state  <= WAIT_IDLE;
         wr_dly <= 1'b1;
      end else begin
         state <= state_nxt;
         if (cpu_ce)
            wr_dly <= wait_n;
      end
   end

   assign wait_n = (state != WAIT_HOLD);

   // Gate closes with wait_n, reopens one cpu_ce after release
   assign wr_gate = wr_dly & wait_n;

   // ================================================
   // Vblank NMI
   // ================================================
   always_ff @(posedge I_CLK12M or negedge I_RESET_n) begin
      if (!I_RESET_n) begin
         vblk_q  <= 1'b1;
         nmi_q_n <= 1'b1;
      end else begin
         vblk_q <= vblk_n;
         if (!nmi_en)
            nmi_q_n <= 1'b1; // Mask clears a pending NMI
         else if (vblk_q && !vblk_n)
            nmi_q_n <= 1'b0; // Falling vblank edge
      end
   end

   assign nmi_n = nmi_q_n | ~nmi_en;

endmodule

/* logic/dkjr_latch_bank.sv */
// Write-only control latches of the CPU board
// Three addressable bit latches plus the sound command latch, written via latch_wr_n
`timescale 1ns/1ps

module dkjr_latch_bank import dkjr_pkg::*; (
   input  logic       I_CLK12M,
   input  logic       I_RESET_n,
   input  addr_t      addr,
   input  data_t      data,
   input  logic [3:0] latch_wr_n, // 0 snd cmd, 1 gfx, 2 snd ctrl, 3 system
   output logic [1:0] gfx_ctrl,   // Tile bank select and sound line
   output ctrl_byte_t sys_ctrl,   // Flip, NMI enable and friends
   output ctrl_byte_t snd_ctrl,   // Sound effect triggers
   output snd_cmd_t   snd_cmd,    // Command to the sound CPU
   output logic       nmi_en
);

   // One bit of an addressable latch takes the new data bit
   function automatic ctrl_byte_t bit_update(input ctrl_byte_t cur,
                                             input logic [2:0] sel,
                                             input logic       d);
      ctrl_byte_t nxt;
      nxt      = cur;
      nxt[sel] = d;
      return nxt;
   endfunction

   // ================================================
   // Sound command, plain 5-bit register
   // ================================================
   always_ff @(posedge I_CLK12M or negedge I_RESET_n) begin
      if (!I_RESET_n) begin
         snd_cmd <= '0;
      end else if (!latch_wr_n[0]) begin
         snd_cmd <= data[$bits(snd_cmd_t)-1:0];
      end
   end

   // ================================================
   // Addressable bit latches
   // ================================================
   // Graphics latch has two cells, only A0 counts
   always_ff @(posedge I_CLK12M or negedge I_RESET_n) begin
      if (!I_RESET_n) begin
         gfx_ctrl <= '0;
      end else if (!latch_wr_n[1]) begin
         gfx_ctrl[addr[0]] <= data[0];
      end
   end

   always_ff @(posedge I_CLK12M or negedge I_RESET_n) begin
      if (!I_RESET_n) begin
         snd_ctrl <= '0;
      end else if (!latch_wr_n[2]) begin
         snd_ctrl <= bit_update(snd_ctrl, addr[2:0], data[0]);
      end
   end

   always_ff @(posedge I_CLK12M or negedge I_RESET_n) begin
      if (!I_RESET_n) begin
         sys_ctrl <= '0;
      end else if (!latch_wr_n[3]) begin
         sys_ctrl <= bit_update(sys_ctrl, addr[2:0], data[0]);
      end
   end

   assign nmi_en = sys_ctrl[NMI_EN_BIT]; // Software NMI mask

endmodule

/* logic/dkjr_pkg.sv */
// Shared bus types, memory map and FSM encoding for the DK Jr bus controller
// Imported by the decoder, latch bank, CPU control and top level
package dkjr_pkg;

   // ================================================
   // Bus and latch widths
   // ================================================
   typedef logic [15:0] addr_t;      // Z80 address bus
   typedef logic [7:0]  data_t;      // Z80 data bus
   typedef logic [4:0]  snd_cmd_t;   // Command byte for the sound CPU
   typedef logic [7:0]  ctrl_byte_t; // One addressable bit latch

   // ================================================
   // Memory map
   // ================================================
   localparam addr_t ROM_TOP       = 16'h5FFF; // Last program ROM byte
   localparam addr_t RAM_BASE      = 16'h6000; // Work RAM, three banks
   localparam addr_t RAM_BANK_SIZE = 16'h0400; // 1 KB per bank
   localparam addr_t OBJ_BASE      = 16'h7000; // Object RAM window
   localparam addr_t VRAM_BASE     = 16'h7400; // Tile RAM window
   localparam addr_t DMA_BASE      = 16'h7800; // DMA controller window
   localparam addr_t IO_BASE       = 16'h7C00; // Input ports and latches
   localparam addr_t IO_STRIDE     = 16'h0080; // Spacing of the I/O windows

   // System latch bit that enables the vblank NMI
   localparam logic [2:0] NMI_EN_BIT = 3'd4;

   // ================================================
   // Wait generator states
   // ================================================
   typedef enum logic [1:0] {
      WAIT_IDLE,    // No wait, CPU runs freely
      WAIT_HOLD,    // VRAM owned by video, CPU stretched
      WAIT_RELEASE  // Vblank seen, let the access finish
   } wait_state_t;

endpackage

/* test/dkjr_bus_ctrl_props.sv */
// Concurrent checks on the bus controller ports
// Bound into the top level and connected to its ports by name
`timescale 1ns/1ps

module dkjr_bus_ctrl_props import dkjr_pkg::*; (
   input logic       I_CLK12M,
   input logic       I_RESET_n,
   input logic       vblk_n,
   input logic [2:0] ram_cs_n,
   input logic       obj_rd_n,
   input logic       vram_rd_n,
   input logic [3:0] in_oe_n,
   input logic       vram_wr_n,
   input logic       wait_n,
   input logic       nmi_n,
   input ctrl_byte_t sys_ctrl
);

   // ================================================
   // Bus and CPU control rules
   // ================================================
   a_one_reader: assert property (@(posedge I_CLK12M) disable iff (!I_RESET_n)
      $countones({~ram_cs_n, ~obj_rd_n, ~vram_rd_n, ~in_oe_n}) <= 1)
      else $error("More than one read source drives the data bus");

   a_nmi_masked: assert property (@(posedge I_CLK12M) disable iff (!I_RESET_n)
      !sys_ctrl[NMI_EN_BIT] |-> nmi_n)
      else $error("nmi_n low with NMI enable clear");

   a_vblk_release: assert property (@(posedge I_CLK12M) disable iff (!I_RESET_n)
      !vblk_n |=> wait_n)   // Vblank frees the CPU within a cycle
      else $error("wait_n still low a cycle after vblank");

   a_no_wr_in_wait: assert property (@(posedge I_CLK12M) disable iff (!I_RESET_n)
      !wait_n |-> vram_wr_n)
      else $error("vram_wr_n low during a wait state");

endmodule

bind dkjr_bus_ctrl dkjr_bus_ctrl_props i_props (.*);

/* test/dkjr_bus_ctrl_tb.sv */
// Directed testbench for the DK Jr CPU bus controller
// Plays Z80 bus cycles and video status into the DUT and checks selects, latches, wait and NMI
`timescale 1ns/1ps

module dkjr_bus_ctrl_tb import dkjr_pkg::*; ();

   logic       I_CLK12M, I_RESET_n, cpu_ce;
   addr_t      addr;
   data_t      data;
   logic       mreq_n, rd_n, wr_n, rfsh_n, vram_busy_n, vblk_n;
   logic       rom_cs_n, vid_grp_n, obj_rq_n, obj_rd_n, obj_wr_n;
   logic       vram_rd_n, vram_wr_n, dma_cs_n, wait_n, nmi_n;
   logic [2:0] ram_cs_n;
   logic [3:0] in_oe_n;
   logic [1:0] gfx_ctrl;
   ctrl_byte_t sys_ctrl, snd_ctrl;
   snd_cmd_t   snd_cmd;

   logic [1:0] ce_cnt;        // CPU clock divider
   integer     seed, errors;
   ctrl_byte_t sys_m, snd_m;  // Latch model
   logic [1:0] gfx_m;
   snd_cmd_t   cmd_m;

   dkjr_bus_ctrl i_dut (.*);

   always #4 I_CLK12M = ~I_CLK12M; // 125 MHz stand-in for 12 MHz

   always @(negedge I_CLK12M) begin
      ce_cnt <= ce_cnt + 2'd1;
      cpu_ce <= (ce_cnt == 2'd3); // One pulse every fourth clock
   end

   // ================================================
   // Check and wait helpers
   // ================================================
   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, got);
      end
   endtask

   function automatic logic probe(input int sel);
      case (sel)
         0:       return wait_n;
         1:       return nmi_n;
         default: return vram_wr_n;
      endcase
   endfunction

   // Polls on falling edges until the level shows up or the limit runs out
   task automatic await_level(input string name, input int sel, input logic level,
                              input int limit);
      int n;
      n = 0;
      do begin
         @(negedge I_CLK12M);
         n++;
      end while (probe(sel) !== level && n < limit);
      assert (probe(sel) === level) else begin
         errors++;
         $display("Timeout at %0t: %s never went %b within %0d cycles", $time, name, level, limit);
      end
   endtask

   // ================================================
   // Bus cycles and expected values
   // ================================================
   task automatic drive_cycle(input addr_t a, input data_t d, input logic wr, input logic rfsh);
      @(negedge I_CLK12M);
      addr   = a;
      data   = d;
      mreq_n = 1'b0;
      rd_n   = wr;
      wr_n   = ~wr;
      rfsh_n = rfsh;
      @(posedge I_CLK12M);
   endtask

   task automatic end_cycle();
      @(negedge I_CLK12M);
      mreq_n = 1'b1;
      rd_n   = 1'b1;
      wr_n   = 1'b1;
      rfsh_n = 1'b1;
   endtask

   // Memory map table with mreq_n low, one strobe active and the write gate open
   function automatic logic [14:0] expected_selects(input addr_t a, input logic wr,
                                                    input logic rfsh);
      logic       rom, vid, obj_rq, obj_rd, obj_wr, vram_rd, vram_wr, dma, obj_in, vram_in;
      logic [2:0] ram;
      logic [3:0] in_oe;
      int         off;
      {rom, vid, obj_rq, obj_rd, obj_wr, vram_rd, vram_wr, dma} = '1;
      ram   = '1;
      in_oe = '1;
      if (rfsh) begin  // Refresh masks everything
         rom = !(a <= ROM_TOP);
         for (int k = 0; k < 3; k++) begin
            off    = int'(a) - int'(RAM_BASE) - k * int'(RAM_BANK_SIZE);
            ram[k] = !(off >= 0 && off < int'(RAM_BANK_SIZE));
         end
         obj_in  = (a >= OBJ_BASE && a < VRAM_BASE);
         vram_in = (a >= VRAM_BASE && a < DMA_BASE);
         vid     = !(obj_in || vram_in);
         obj_rq  = !obj_in;
         obj_rd  = !(obj_in && !wr);
         obj_wr  = !(obj_in && wr);
         vram_rd = !(vram_in && !wr);
         vram_wr = !(vram_in && wr);
         dma     = !(a >= DMA_BASE && a < IO_BASE);
         for (int k = 0; k < 4; k++) begin
            off      = int'(a) - int'(IO_BASE) - k * int'(IO_STRIDE);
            in_oe[k] = !(off >= 0 && off < int'(IO_STRIDE) && !wr);
         end
      end
      return {rom, ram, vid, obj_rq, obj_rd, obj_wr, vram_rd, vram_wr, dma, in_oe};
   endfunction

   task automatic check_latch_outputs();
      compare("snd_cmd", snd_cmd, cmd_m);
      compare("gfx_ctrl", gfx_ctrl, gfx_m);
      compare("snd_ctrl", snd_ctrl, snd_m);
      compare("sys_ctrl", sys_ctrl, sys_m);
   endtask

   // Write cycle to the I/O area with the model updated and all latches checked a cycle later
   task automatic write_latch(input addr_t a, input data_t d);
      drive_cycle(a, d, 1'b1, 1'b1);
      end_cycle();
      if (a >= IO_BASE && a < IO_BASE + 4 * IO_STRIDE) begin
         case (int'((a - IO_BASE) / IO_STRIDE))
            0: cmd_m = d[4:0];
            1: gfx_m[a[0]] = d[0];      // Two cells selected by A0
            2: snd_m[a[2:0]] = d[0];
            default: sys_m[a[2:0]] = d[0];
         endcase
      end
      check_latch_outputs();
   endtask

   // ================================================
   // Tests
   // ================================================
   task automatic check_bit_latches(input int count);
      int win;
      repeat (count) begin
         win = 1 + ($unsigned($random(seed)) % 3); // gfx, sound ctrl or system
         write_latch(IO_BASE + addr_t'(win) * IO_STRIDE + addr_t'($random(seed) & 32'h7F),
                     data_t'($random(seed)));
      end
   endtask

   task automatic check_sound_cmd(input int count);
      repeat (count)
         write_latch(IO_BASE + addr_t'($random(seed) & 32'h7F), data_t'($random(seed)));
   endtask

   task automatic check_nmi();
      addr_t en_addr;
      en_addr = IO_BASE + 3 * IO_STRIDE + addr_t'(NMI_EN_BIT);
      write_latch(en_addr, 8'h00);          // Masked first
      vblk_n = 1'b0;
      repeat (4) begin
         @(negedge I_CLK12M);
         compare("nmi_n", nmi_n, 1'b1);
      end
      vblk_n = 1'b1;
      @(negedge I_CLK12M);
      write_latch(en_addr, 8'h01);
      vblk_n = 1'b0;                        // Vblank edge with NMI enabled
      await_level("nmi_n", 1, 1'b0, 4);
      write_latch(en_addr, 8'h00);
      compare("nmi_n", nmi_n, 1'b1);        // Mask clears it at once
      vblk_n = 1'b1;
   endtask

   task automatic check_wait_states();
      addr_t a;
      a = VRAM_BASE + addr_t'($random(seed) & 32'h3FF);
      @(negedge I_CLK12M);
      vram_busy_n = 1'b0;                   // Video owns tile RAM
      drive_cycle(a, data_t'($random(seed)), 1'b1, 1'b1);
      await_level("wait_n", 0, 1'b0, 16);
      repeat (12) begin                     // Stretched cycle holds
         @(negedge I_CLK12M);
         compare("wait_n", wait_n, 1'b0);
         compare("vram_wr_n", vram_wr_n, 1'b1);
      end
      vblk_n = 1'b0;
      await_level("wait_n", 0, 1'b1, 4);    // Vblank release
      await_level("vram_wr_n", 2, 1'b0, 16); // Pending write goes out
      end_cycle();
      vblk_n      = 1'b1;
      vram_busy_n = 1'b1;
      repeat (8) @(negedge I_CLK12M);       // Let the FSM settle to idle
   endtask

   task automatic check_decode(input int count, input logic rfsh);
      addr_t       a;
      logic        wr;
      int          r;
      logic [14:0] exp;
      for (int n = 0; n < count; n++) begin
         a = addr_t'($random(seed));
         if (n % 4 != 0)
            a[15:12] = {3'b011, a[12]};     // Bias toward pages 6 and 7
         r  = $random(seed);
         wr = r[0];
         drive_cycle(a, data_t'($random(seed)), wr, rfsh);
         exp = expected_selects(a, wr, rfsh);
         compare("rom_cs_n", rom_cs_n, exp[14]);
         compare("ram_cs_n", ram_cs_n, exp[13:11]);
         compare("vid_grp_n", vid_grp_n, exp[10]);
         compare("obj_rq_n", obj_rq_n, exp[9]);
         compare("obj_rd_n", obj_rd_n, exp[8]);
         compare("obj_wr_n", obj_wr_n, exp[7]);
         compare("vram_rd_n", vram_rd_n, exp[6]);
         compare("vram_wr_n", vram_wr_n, exp[5]);
         compare("dma_cs_n", dma_cs_n, exp[4]);
         compare("in_oe_n", in_oe_n, exp[3:0]);
         end_cycle();
      end
   endtask

   // ================================================
   // Main sequence
   // ================================================
   initial begin
      seed = 32'heb75;
      errors = 0;
      {I_CLK12M, I_RESET_n, cpu_ce, ce_cnt} = '0;
      {addr, data} = '0;
      {mreq_n, rd_n, wr_n, rfsh_n, vram_busy_n, vblk_n} = '1;
      {sys_m, snd_m, gfx_m, cmd_m} = '0;
      repeat (8) @(posedge I_CLK12M);
      @(negedge I_CLK12M);
      I_RESET_n = 1'b1;
      check_latch_outputs();                // All clear after reset
      compare("wait_n", wait_n, 1'b1);
      compare("nmi_n", nmi_n, 1'b1);
      check_bit_latches(40);
      check_sound_cmd(10);
      check_nmi();
      check_wait_states();
      check_decode(200, 1'b1);
      check_decode(40, 1'b0);               // Refresh cycles
      $display("Run complete: %0d errors", errors);
      if (errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule
